// File: ahbBusUnit.f
+incdir+common
common/ahbBusPkg.sv
ahbBusUnit/busArbiter.sv
ahbBusUnit/addressPhase.sv
ahbBusUnit/readAlign.sv
ahbBusUnit/amoAlu.sv
ahbBusUnit/ahbBusUnit.sv
tb/ahbMemoryModel.sv
tb/ahbBusUnit_sva.sv
tb/ahbBusUnitTb.sv

// File: ahbBusUnit/addressPhase.sv
// AHB-Lite address phase muxing and data-phase registers, driven by the bus-state FSM
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module addressPhase
  import ahbBusPkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  busStateT              busState,
  input  busStateT              nextBusState,
  input  logic                  HREADY,
  input  logic [`PA_BITS-1:0]   memAdr,
  input  logic [`PA_BITS-1:0]   instrAdr,
  input  logic [`PA_BITS-1:0]   mmuAdr,
  input  logic [1:0]            memSize,
  input  logic                  unsignedLoad,
  input  logic [`XLEN-1:0]      writeData,
  input  logic [`XLEN-1:0]      amoResult,
  output logic [`PA_BITS-1:0]   HADDR,
  output logic [2:0]            HSIZE,
  output logic [1:0]            HTRANS,
  output logic                  HWRITE,
  output logic [2:0]            HBURST,
  output logic [3:0]            HPROT,
  output logic                  HMASTLOCK,
  output logic [`XLEN-1:0]      HWDATA,
  output logic [1:0]            adrLowD,
  output logic [1:0]            sizeD,
  output logic                  unsignedD
);

  logic            amoWrite;
  logic [`XLEN-1:0] storeData;

  // Page-table walks and fetches are whole words
  always_comb begin
    case (nextBusState)
      MMUWALK: begin
        HADDR = mmuAdr;
        HSIZE = `HSIZE_WORD;
      end
      INSTRREAD: begin
        HADDR = instrAdr;
        HSIZE = `HSIZE_WORD;
      end
      default: begin
        HADDR = memAdr;
        HSIZE = {1'b0, memSize};
      end
    endcase
  end

  assign HTRANS    = (nextBusState != IDLE) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
  assign HWRITE    = (nextBusState == DATAWRITE) || (nextBusState == ATOMICWRITE);
  assign HBURST    = `HBURST_SINGLE;
  assign HPROT     = `HPROT_DATA;
  assign HMASTLOCK = 1'b0;

  // Atomic result is ready only while the read data phase completes
  assign amoWrite  = (nextBusState == ATOMICWRITE) && (busState == ATOMICREAD);
  assign storeData = amoWrite ? amoResult : writeData;

  // Alignment controls follow the accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      adrLowD   <= 2'b00;
      sizeD     <= 2'b10;
      unsignedD <= 1'b0;
    end else if (HREADY) begin
      adrLowD   <= HADDR[1:0];
      sizeD     <= HSIZE[1:0];
      unsignedD <= unsignedLoad;
    end
  end

  // Write data lags its address by one phase
  always_ff @(posedge HCLK) begin
    if (HREADY) begin
      HWDATA <= storeData;
    end
  end

endmodule

// File: ahbBusUnit/ahbBusUnit.sv
// Top of the AHB-Lite bus unit; connects the arbiter, address phase, read path and atomic ALU
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module ahbBusUnit
  import ahbBusPkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  // MMU walker
  input  logic                mmuTranslate,
  input  logic [`PA_BITS-1:0] mmuAdr,
  output logic                mmuReady,
  output logic [`XLEN-1:0]    mmuReadPte,
  // Data side and atomics
  input  logic                atomicReq,
  input  amoOpT               amoOp,
  input  logic                memRead,
  input  logic                memWrite,
  input  logic [`PA_BITS-1:0] memAdr,
  input  logic [1:0]          memSize,
  input  logic                unsignedLoad,
  input  logic [`XLEN-1:0]    writeData,
  output logic                dataAck,
  output logic                commit,
  output logic                dataStall,
  output logic [`XLEN-1:0]    readDataM,
  output logic [`XLEN-1:0]    readDataW,
  input  logic                StallW,
  // Instruction side
  input  logic                instrRead,
  input  logic [`PA_BITS-1:0] instrAdr,
  output logic                instrAck,
  output logic [`XLEN-1:0]    instrRData,
  // PMA checker
  input  logic                dSquash,
  input  logic                iSquash,
  output logic                readAccess,
  output logic                writeAccess,
  output logic                atomicAccess,
  output logic                executeAccess,
  // AHB-Lite manager port
  input  logic                HREADY,
  input  logic [`XLEN-1:0]    HRDATA,
  output logic [`PA_BITS-1:0] HADDR,
  output logic [2:0]          HSIZE,
  output logic [1:0]          HTRANS,
  output logic                HWRITE,
  output logic [2:0]          HBURST,
  output logic [3:0]          HPROT,
  output logic                HMASTLOCK,
  output logic [`XLEN-1:0]    HWDATA
);

  busStateT         busState;
  busStateT         nextBusState;
  logic             captureRead;
  logic [1:0]       adrLowD;
  logic [1:0]       sizeD;
  logic             unsignedD;
  logic [`XLEN-1:0] amoResult;

  busArbiter arbiter0 (
    .HCLK, .HRESETn,
    .mmuTranslate, .atomicReq, .memRead, .memWrite, .instrRead,
    .HREADY, .dSquash, .iSquash,
    .busState, .nextBusState,
    .readAccess, .writeAccess, .atomicAccess, .executeAccess,
    .mmuReady, .dataAck, .instrAck, .captureRead, .commit, .dataStall
  );

  addressPhase adrPhase0 (
    .HCLK, .HRESETn, .busState, .nextBusState, .HREADY,
    .memAdr, .instrAdr, .mmuAdr, .memSize, .unsignedLoad, .writeData, .amoResult,
    .HADDR, .HSIZE, .HTRANS, .HWRITE, .HBURST, .HPROT, .HMASTLOCK, .HWDATA,
    .adrLowD, .sizeD, .unsignedD
  );

  readAlign readAlign0 (
    .HCLK, .HRESETn, .HRDATA, .adrLowD, .sizeD, .unsignedD,
    .captureRead, .StallW, .busState,
    .readDataM, .readDataW, .instrRData, .mmuReadPte
  );

  // Old word from the atomic read phase feeds the ALU
  amoAlu amoAlu0 (
    .srcA   (readDataM),
    .srcB   (writeData),
    .amoOp  (amoOp),
    .result (amoResult)
  );

endmodule

// File: ahbBusUnit/amoAlu.sv
// Store value for RV32A atomics, from the old memory word and the register operand
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module amoAlu
  import ahbBusPkg::*;
(
  input  logic [`XLEN-1:0] srcA,
  input  logic [`XLEN-1:0] srcB,
  input  amoOpT            amoOp,
  output logic [`XLEN-1:0] result
);

  logic signedLess;
  logic unsignedLess;

  // srcA is the old word, srcB the operand
  assign signedLess   = $signed(srcA) < $signed(srcB);
  assign unsignedLess = srcA < srcB;

  always_comb begin
    case (amoOp)
      AMOSWAP: result = srcB;
      AMOADD:  result = srcA + srcB;
      AMOAND:  result = srcA & srcB;
      AMOOR:   result = srcA | srcB;
      AMOXOR:  result = srcA ^ srcB;
      // Min and max keep whichever word wins the compare
      AMOMIN:  result = signedLess ? srcA : srcB;
      AMOMAX:  result = signedLess ? srcB : srcA;
      AMOMINU: result = unsignedLess ? srcA : srcB;
      AMOMAXU: result = unsignedLess ? srcB : srcA;
      default: result = srcB;
    endcase
  end

endmodule

// File: ahbBusUnit/busArbiter.sv
// Bus-state FSM that picks the next AHB transfer by fixed priority and acknowledges requesters
`timescale 1ns/1ps

module busArbiter
  import ahbBusPkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  // Requests
  input  logic     mmuTranslate,
  input  logic     atomicReq,
  input  logic     memRead,
  input  logic     memWrite,
  input  logic     instrRead,
  // Bus handshake
  input  logic     HREADY,
  // Squash from the PMA checker
  input  logic     dSquash,
  input  logic     iSquash,
  output busStateT busState,
  output busStateT nextBusState,
  // Proposed access type for the PMA checker
  output logic     readAccess,
  output logic     writeAccess,
  output logic     atomicAccess,
  output logic     executeAccess,
  // Acknowledges
  output logic     mmuReady,
  output logic     dataAck,
  output logic     instrAck,
  output logic     captureRead,
  output logic     commit,
  output logic     dataStall
);

  busStateT proposedState;
  logic     squash;

  ////////////////////////////////////////////////////////////
  // Next-state proposal
  ////////////////////////////////////////////////////////////

  // Priority is MMU walk, atomic, load, store, then fetch
  // A pending fetch follows a data or atomic transfer directly
  always_comb begin
    case (busState)
      IDLE: begin
        if (mmuTranslate) proposedState = MMUWALK;
        else if (atomicReq) proposedState = ATOMICREAD;
        else if (memRead) proposedState = DATAREAD;
        else if (memWrite) proposedState = DATAWRITE;
        else if (instrRead) proposedState = INSTRREAD;
        else proposedState = IDLE;
      end
      MMUWALK: proposedState = HREADY ? IDLE : MMUWALK;
      // Write address phase overlaps the read data phase
      ATOMICREAD: proposedState = HREADY ? ATOMICWRITE : ATOMICREAD;
      ATOMICWRITE, DATAREAD, DATAWRITE: begin
        if (!HREADY) proposedState = busState;
        else if (instrRead) proposedState = INSTRREAD;
        else proposedState = IDLE;
      end
      INSTRREAD: proposedState = HREADY ? IDLE : INSTRREAD;
      default: proposedState = IDLE;
    endcase
  end

  // Flags describe the proposed access so the checker can veto it
  assign readAccess    = (proposedState == MMUWALK) || (proposedState == DATAREAD) ||
                         (proposedState == ATOMICREAD);
  assign writeAccess   = (proposedState == DATAWRITE) || (proposedState == ATOMICWRITE);
  assign atomicAccess  = (proposedState == ATOMICREAD) || (proposedState == ATOMICWRITE);
  assign executeAccess = (proposedState == INSTRREAD);

  // A vetoed access never reaches the bus
  assign squash       = dSquash | iSquash;
  assign nextBusState = squash ? IDLE : proposedState;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      busState <= IDLE;
    end else begin
      busState <= nextBusState;
    end
  end

  ////////////////////////////////////////////////////////////
  // Acknowledges and stall
  ////////////////////////////////////////////////////////////

  // Each ack marks the data phase that completes this cycle
  assign mmuReady = (busState == MMUWALK) && HREADY;
  assign instrAck = (busState == INSTRREAD) && HREADY;
  // Atomics acknowledge only after the write phase
  assign dataAck  = ((busState == DATAREAD) || (busState == DATAWRITE) ||
                     (busState == ATOMICWRITE)) && HREADY;

  // Read data worth keeping for writeback
  assign captureRead = ((busState == DATAREAD) || (busState == ATOMICREAD)) && HREADY;

  // Data-side transfer in its data phase
  assign commit = (busState == DATAREAD) || (busState == DATAWRITE) ||
                  (busState == ATOMICREAD) || (busState == ATOMICWRITE);

  // Hold the pipeline while a data-side transfer is issued or waiting
  assign dataStall = (nextBusState == DATAREAD) || (nextBusState == DATAWRITE) ||
                     (nextBusState == ATOMICREAD) || (nextBusState == ATOMICWRITE);

endmodule

// File: ahbBusUnit/readAlign.sv
// Load data extraction and writeback-stage capture of read data across pipeline stalls
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module readAlign
  import ahbBusPkg::*;
(
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic [`XLEN-1:0] HRDATA,
  input  logic [1:0]       adrLowD,
  input  logic [1:0]       sizeD,
  input  logic             unsignedD,
  input  logic             captureRead,
  input  logic             StallW,
  input  busStateT         busState,
  output logic [`XLEN-1:0] readDataM,
  output logic [`XLEN-1:0] readDataW,
  output logic [`XLEN-1:0] instrRData,
  output logic [`XLEN-1:0] mmuReadPte
);

  logic [7:0]       byteSel;
  logic [15:0]      halfSel;
  logic [`XLEN-1:0] capturedData;
  logic             capturedAvail;
  logic             holdW;
  logic [`XLEN-1:0] readDataWNext;

  ////////////////////////////////////////////////////////////
  // Subword extraction
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (adrLowD)
      2'b00: byteSel = HRDATA[7:0];
      2'b01: byteSel = HRDATA[15:8];
      2'b10: byteSel = HRDATA[23:16];
      default: byteSel = HRDATA[31:24];
    endcase
  end

  assign halfSel = adrLowD[1] ? HRDATA[31:16] : HRDATA[15:0];

  // Sign bit is replicated unless the load is unsigned
  always_comb begin
    case (sizeD)
      2'b00: readDataM = {{(`XLEN-8){~unsignedD & byteSel[7]}}, byteSel};
      2'b01: readDataM = {{(`XLEN-16){~unsignedD & halfSel[15]}}, halfSel};
      default: readDataM = HRDATA;
    endcase
  end

  // Fetches and PTEs are whole words
  assign instrRData = HRDATA;
  assign mmuReadPte = HRDATA;

  ////////////////////////////////////////////////////////////
  // Writeback copy
  ////////////////////////////////////////////////////////////

  // Latest completed read, kept until the stall lets W advance
  always_ff @(posedge HCLK) begin
    if (captureRead) begin
      capturedData <= readDataM;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      capturedAvail <= 1'b0;
    end else begin
      capturedAvail <= StallW ? (capturedAvail | captureRead) : 1'b0;
    end
  end

  // An atomic holds the pipeline itself, its old word goes straight to W
  assign holdW = StallW && (busState != ATOMICREAD);

  always_comb begin
    if (holdW) readDataWNext = readDataW;
    else if (captureRead) readDataWNext = readDataM;
    else if (capturedAvail) readDataWNext = capturedData;
    else readDataWNext = readDataW;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      readDataW <= '0;
    end else begin
      readDataW <= readDataWNext;
    end
  end

endmodule

// File: common/ahbBusPkg.sv
// Bus unit types shared by the AHB-Lite blocks; import with ahbBusPkg::*
package ahbBusPkg;

  // Owner of the current or proposed transfer
  typedef enum logic [2:0] {
    IDLE,
    MMUWALK,
    ATOMICREAD,
    ATOMICWRITE,
    DATAREAD,
    DATAWRITE,
    INSTRREAD
  } busStateT;

  // Atomic memory operation selector
  typedef enum logic [3:0] {
    AMOSWAP,
    AMOADD,
    AMOAND,
    AMOOR,
    AMOXOR,
    AMOMIN,
    AMOMAX,
    AMOMINU,
    AMOMAXU
  } amoOpT;

endpackage

// File: common/ahbBus_consts.svh
// Widths and AHB-Lite encodings for the bus unit; include where a module needs them
`ifndef AHBBUS_CONSTS_SVH
`define AHBBUS_CONSTS_SVH

// Data and physical address widths
`define XLEN    32
`define PA_BITS 32

// HTRANS codes, only single transfers are issued
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// Word size, used by page-table and instruction reads
`define HSIZE_WORD 3'b010

// Single transfer burst code
`define HBURST_SINGLE 3'b000

// Data access, privileged, non-bufferable
`define HPROT_DATA 4'b0011

`endif

// File: tb/ahbBusUnitTb.sv
// Testbench for the bus unit; replays the golden vectors against a wait-state memory
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module ahbBusUnitTb
  import ahbBusPkg::*;
();

  localparam logic [31:0] FILL_KEY = 32'hF0E0_8000;
  localparam int MAX_VEC = 64;

  logic HCLK, HRESETn;
  logic mmuTranslate, atomicReq, memRead, memWrite, instrRead;
  logic [31:0] mmuAdr, memAdr, instrAdr, writeData;
  logic [1:0] memSize;
  logic unsignedLoad, StallW, dSquash, iSquash;
  amoOpT amoOp;
  logic mmuReady, dataAck, instrAck, commit, dataStall;
  logic readAccess, writeAccess, atomicAccess, executeAccess;
  logic [31:0] mmuReadPte, readDataM, readDataW, instrRData;
  logic HREADY, HWRITE, HMASTLOCK;
  logic [31:0] HRDATA, HADDR, HWDATA;
  logic [2:0] HSIZE, HBURST;
  logic [1:0] HTRANS;
  logic [3:0] HPROT;

  // Golden columns
  logic [31:0] vOp [MAX_VEC];
  logic [31:0] vAdr [MAX_VEC];
  logic [31:0] vSize [MAX_VEC];
  logic [31:0] vUns [MAX_VEC];
  logic [31:0] vAmo [MAX_VEC];
  logic [31:0] vWdata [MAX_VEC];
  logic [31:0] vSquash [MAX_VEC];
  logic [31:0] vStall [MAX_VEC];
  logic [31:0] vExp [MAX_VEC];
  int numVectors;
  logic vectorsLoaded;
  int errorCount;

  ahbBusUnit dut0 (.*);

  ahbMemoryModel #(.FILL_KEY(FILL_KEY)) mem0 (
    .HCLK, .HRESETn, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HWDATA, .HREADY, .HRDATA
  );

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic stopRun(input string why);
    errorCount++;
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkData(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stopRun($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkState(input string what, input busStateT got, input busStateT exp);
    if (got !== exp)
      stopRun($sformatf("[FAIL] t=%0t %s: got %s, expected %s", $time, what,
                        got.name(), exp.name()));
  endtask

  // Checker flags and stall for a lone request in its first address phase
  task automatic verifyAccessFlags(input int op);
    logic [31:0] exp;
    exp = '0;
    exp[0] = (op == 4);
    exp[1] = (op == 1);
    exp[2] = (op == 3);
    exp[3] = (op <= 2);
    exp[4] = (op >= 1) && (op <= 3);
    checkData("access flags and stall",
              {27'b0, dataStall, readAccess, writeAccess, atomicAccess, executeAccess}, exp);
    checkData("fixed bus controls", {24'b0, HMASTLOCK, HPROT, HBURST},
              {24'b0, 1'b0, `HPROT_DATA, `HBURST_SINGLE});
  endtask

  // Memory contents before any store
  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ FILL_KEY;
  endfunction

  task automatic clearRequests();
    mmuTranslate = 1'b0;
    atomicReq    = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    instrRead    = 1'b0;
    dSquash      = 1'b0;
    iSquash      = 1'b0;
  endtask

  task automatic loadVectors();
    int fd;
    string line;
    logic [31:0] c [9];
    fd = $fopen("tb/ahbBusUnit_golden.txt", "r");
    if (fd == 0) stopRun("Could not open the golden vector file");
    numVectors = 0;
    while (!$feof(fd) && numVectors < MAX_VEC) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8]) == 9) begin
        vOp[numVectors] = c[0];
        vAdr[numVectors] = c[1];
        vSize[numVectors] = c[2];
        vUns[numVectors] = c[3];
        vAmo[numVectors] = c[4];
        vWdata[numVectors] = c[5];
        vSquash[numVectors] = c[6];
        vStall[numVectors] = c[7];
        vExp[numVectors] = c[8];
        numVectors++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Vector kinds
  ////////////////////////////////////////////////////////////

  // Single request, optionally under a writeback stall
  task automatic runAccess(input int i);
    logic [31:0] prevW;
    int cycles;
    bit done;
    logic rightAck;
    prevW = readDataW;
    cycles = 0;
    done = 1'b0;
    StallW = (vOp[i] == 2) && (vStall[i] != 0);
    case (vOp[i])
      0: mmuTranslate = 1'b1;
      1: atomicReq = 1'b1;
      2: memRead = 1'b1;
      3: memWrite = 1'b1;
      default: instrRead = 1'b1;
    endcase
    // Proposal shows combinationally in the request cycle
    #1;
    verifyAccessFlags(vOp[i]);
    while (!done) begin
      @(negedge HCLK);
      cycles++;
      if (cycles > 40) stopRun("No acknowledge arrived for the request");
      if (StallW) checkData("readDataW held in stall", readDataW, prevW);
      if (mmuReady || dataAck || instrAck) begin
        done = 1'b1;
        case (vOp[i])
          0: rightAck = mmuReady;
          4: rightAck = instrAck;
          default: rightAck = dataAck;
        endcase
        if (!rightAck) stopRun("Acknowledge came from the wrong requester");
        checkData("commit", {31'b0, commit}, {31'b0, (vOp[i] >= 1) && (vOp[i] <= 3)});
        case (vOp[i])
          0: checkData("mmuReadPte", mmuReadPte, vExp[i]);
          1: checkData("atomic old word", readDataW, vExp[i]);
          2: checkData("readDataM", readDataM, vExp[i]);
          4: checkData("instrRData", instrRData, vExp[i]);
          default: ;
        endcase
        clearRequests();
      end
    end
    if (StallW) begin
      repeat (vStall[i]) begin
        @(negedge HCLK);
        checkData("readDataW held after load", readDataW, prevW);
      end
      StallW = 1'b0;
      @(negedge HCLK);
      checkData("readDataW after stall", readDataW, vExp[i]);
    end
  endtask

  // Request vetoed by the checker for a number of cycles
  task automatic runSquash(input int i);
    if (vOp[i] == 4) instrRead = 1'b1;
    else memRead = 1'b1;
    dSquash = vSquash[i][0];
    iSquash = vSquash[i][1];
    repeat (vStall[i]) begin
      @(negedge HCLK);
      checkData("HTRANS under squash", {30'b0, HTRANS}, {30'b0, `HTRANS_IDLE});
      if (mmuReady || dataAck || instrAck) stopRun("Acknowledge seen for a squashed request");
    end
    clearRequests();
  endtask

  // MMU, load and fetch raised together
  task automatic runPriority(input int i);
    int stage;
    int cycles;
    mmuAdr = vAdr[i];
    memAdr = vAdr[i] + 4;
    instrAdr = vAdr[i] + 8;
    memSize = 2'b10;
    mmuTranslate = 1'b1;
    memRead = 1'b1;
    instrRead = 1'b1;
    #1;
    checkData("first HADDR", HADDR, vExp[i]);
    checkData("first HWRITE", {31'b0, HWRITE}, 32'h0);
    checkState("first owner", dut0.nextBusState, MMUWALK);
    stage = 0;
    cycles = 0;
    while (stage < 3) begin
      @(negedge HCLK);
      cycles++;
      if (cycles > 60) stopRun("Losing requesters were never served");
      if (mmuReady) begin
        if (stage != 0) stopRun("MMU served out of priority order");
        checkData("priority PTE", mmuReadPte, fillWord(mmuAdr));
        mmuTranslate = 1'b0;
        stage = 1;
      end else if (dataAck) begin
        if (stage != 1) stopRun("Load served out of priority order");
        checkData("priority load", readDataM, fillWord(memAdr));
        memRead = 1'b0;
        stage = 2;
      end else if (instrAck) begin
        if (stage != 2) stopRun("Fetch served out of priority order");
        checkData("priority fetch", instrRData, fillWord(instrAdr));
        instrRead = 1'b0;
        stage = 3;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    errorCount = 0;
    vectorsLoaded = 1'b0;
    HRESETn = 1'b0;
    clearRequests();
    mmuAdr = '0;
    memAdr = '0;
    instrAdr = '0;
    writeData = '0;
    memSize = 2'b10;
    unsignedLoad = 1'b0;
    StallW = 1'b0;
    amoOp = AMOSWAP;
    loadVectors();
    vectorsLoaded = 1'b1;
    repeat (3) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    for (int i = 0; i < numVectors; i++) begin
      mmuAdr = vAdr[i];
      memAdr = vAdr[i];
      instrAdr = vAdr[i];
      memSize = vSize[i][1:0];
      unsignedLoad = vUns[i][0];
      amoOp = amoOpT'(vAmo[i][3:0]);
      writeData = vWdata[i];
      if (vSquash[i] != 0) runSquash(i);
      else if (vOp[i] == 5) runPriority(i);
      else runAccess(i);
      @(negedge HCLK);
    end
    if (errorCount == 0 && numVectors > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("No vectors were run or a check failed");
      $display("Simulation failed");
    end
    $finish;
  end

  // 20 cycles per vector plus reset
  initial begin
    wait (vectorsLoaded);
    #((numVectors * 20 + 10) * 100);
    $display("Timeout: the vectors did not finish in time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tb/ahbBusUnit_golden.txt
# op(0 mmu,1 amo,2 load,3 store,4 fetch,5 priority) adr size uns amoOp wdata squash stall expect
# squash bit0 dSquash bit1 iSquash, stall gives squash or StallW cycles, all values hex
5 00000020 2 0 0 00000000 0 0 00000020
2 00000010 2 0 0 00000000 0 0 F0E08010
2 00000011 0 0 0 00000000 0 0 FFFFFF80
2 00000011 0 1 0 00000000 0 0 00000080
2 00000012 0 0 0 00000000 0 0 FFFFFFE0
2 00000012 1 0 0 00000000 0 0 FFFFF0E0
2 00000010 1 1 0 00000000 0 0 00008010
2 00000010 1 0 0 00000000 0 0 FFFF8010
4 00000040 2 0 0 00000000 0 0 F0E08040
0 00000044 2 0 0 00000000 0 0 F0E08044
3 00000031 0 0 0 00005A00 0 0 00000000
2 00000030 2 0 0 00000000 0 0 F0E05A30
3 00000036 1 0 0 BEEF0000 0 0 00000000
2 00000034 2 0 0 00000000 0 0 BEEF8034
1 00000050 2 0 1 00000010 0 0 F0E08050
2 00000050 2 0 0 00000000 0 0 F0E08060
1 00000054 2 0 6 00000005 0 0 F0E08054
2 00000054 2 0 0 00000000 0 0 00000005
1 00000058 2 0 4 FFFF0000 0 0 F0E08058
2 00000058 2 0 0 00000000 0 0 0F1F8058
1 0000005C 2 0 7 00001234 0 0 F0E0805C
2 0000005C 2 0 0 00000000 0 0 00001234
2 00000060 2 0 0 00000000 1 4 00000000
4 00000064 2 0 0 00000000 2 3 00000000
2 00000070 2 0 0 00000000 0 3 F0E08070
2 00000071 0 0 0 00000000 0 2 FFFFFF80

// File: tb/ahbBusUnit_sva.sv
// Protocol assertions for the bus unit, bound into every ahbBusUnit instance
`timescale 1ns/1ps
`include "ahbBus_consts.svh"

module ahbBusUnit_sva
  import ahbBusPkg::*;
(
  input logic        HCLK,
  input logic        HRESETn,
  input logic        HREADY,
  input logic [1:0]  HTRANS,
  input logic [31:0] HADDR,
  input logic        mmuReady,
  input logic        dataAck,
  input logic        instrAck,
  input logic        dSquash,
  input logic        iSquash,
  input busStateT    busState
);

  // Pending address phase holds while the subordinate keeps waiting
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!HREADY && HTRANS == `HTRANS_NONSEQ) |=>
      (HREADY || ($stable(HTRANS) && $stable(HADDR))))
    else $error("address phase changed under wait state");

  // One requester served per cycle
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({mmuReady, dataAck, instrAck}))
    else $error("more than one acknowledge");

  // Squashed proposal out of IDLE starts nothing
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    ((dSquash || iSquash) && busState == IDLE) |=> !(mmuReady || dataAck || instrAck))
    else $error("acknowledge after squash");

endmodule

bind ahbBusUnit ahbBusUnit_sva sva0 (.*);

// File: tb/ahbMemoryModel.sv
// AHB-Lite subordinate memory for the testbench; 256 words with random wait states
`timescale 1ns/1ps

module ahbMemoryModel #(
  parameter logic [31:0] FILL_KEY = 32'h0
) (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic [31:0] HADDR,
  input  logic [1:0]  HTRANS,
  input  logic        HWRITE,
  input  logic [2:0]  HSIZE,
  input  logic [31:0] HWDATA,
  output logic        HREADY,
  output logic [31:0] HRDATA
);

  logic [31:0] mem [256];
  integer      seed;
  int          waitCount;
  logic        active;
  logic        writeD;
  logic [7:0]  idxD;
  logic [1:0]  lowD;
  logic [2:0]  sizeD;
  logic [3:0]  laneEn;

  // Each word starts as its byte address XOR a key
  initial begin
    seed = 32'hd5d415f4;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {22'b0, i[7:0], 2'b00} ^ FILL_KEY;
    end
  end

  assign HREADY = !active || (waitCount == 0);
  assign HRDATA = mem[idxD];

  // Byte lanes of the data phase write
  always_comb begin
    case (sizeD[1:0])
      2'b00: laneEn = 4'b0001 << lowD;
      2'b01: laneEn = lowD[1] ? 4'b1100 : 4'b0011;
      default: laneEn = 4'b1111;
    endcase
  end

  always @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      active    <= 1'b0;
      writeD    <= 1'b0;
      idxD      <= 8'h00;
      lowD      <= 2'b00;
      sizeD     <= 3'b010;
      waitCount <= 0;
    end else if (!HREADY) begin
      waitCount <= waitCount - 1;
    end else begin
      if (active && writeD) begin
        for (int b = 0; b < 4; b++) begin
          if (laneEn[b]) mem[idxD][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
      // New address phase, 0 to 2 wait states
      active    <= HTRANS[1];
      writeD    <= HWRITE;
      idxD      <= HADDR[9:2];
      lowD      <= HADDR[1:0];
      sizeD     <= HSIZE;
      waitCount <= HTRANS[1] ? int'({$random(seed)} % 3) : 0;
    end
  end

endmodule
